/* include/videoPost_settings.svh */
// Raster geometry, FIFO sizing and read lead macros, included by the RTL and the testbench
`ifndef VIDEOPOST_SETTINGS_SVH
`define VIDEOPOST_SETTINGS_SVH

// ------------------------------
// Horizontal timing in pixel clocks
// ------------------------------
`define HACTIVE 16
`define HFRONT 3
`define HSYNC 4
`define HBACK 5

// ------------------------------
// Vertical timing in lines
// ------------------------------
`define VACTIVE 4
`define VFRONT 1
`define VSYNC 2
`define VBACK 2

// ------------------------------
// Buffering
// ------------------------------
// Input FIFO words
`define FIFODEPTH 64
// One full line buffered before timing starts
`define PREFILL `HACTIVE
// Read request to data enable distance
`define READLEAD 2

`endif

/* rtl/videoTimingPkg.sv */
// Line phase type shared by the raster generator and the testbench raster model
package videoTimingPkg;

	// ------------------------------
	// Raster phases
	// ------------------------------
	// Encoding follows raster order so a plain increment
	// steps to the next phase and wraps after front porch
	typedef enum logic [1:0]
	{
		// Sync pulse
		PH_SYNC = 2'd0,
		// Back porch
		PH_BACK = 2'd1,
		// Visible pixels or lines
		PH_ACTIVE = 2'd2,
		// Front porch
		PH_FRONT = 2'd3
	} linePhase_t;

	// Same type serves horizontal and vertical counters

endpackage

/* rtl/videoCtrlPkg.sv */
// Register map, video source select and colour-bar table for the control path
package videoCtrlPkg;

	// Word address, taken from Wishbone address bits 3:2
	typedef enum logic [1:0]
	{
		REG_CTRL = 2'd0,
		REG_STATUS = 2'd1,
		REG_FRAMES = 2'd2
	} regAddr_t;

	// Output source, CTRL bit 1
	typedef enum logic
	{
		SRC_LIVE = 1'b0,
		SRC_BARS = 1'b1
	} videoSrc_t;

	// ------------------------------
	// Colour bars, left to right
	// ------------------------------
	// Already in transmitter order, chroma high byte and luma low byte
	localparam logic [15:0] barColour [0:7] = '{
		16'h80EB, 16'h10D2, 16'hA6AA, 16'h3691,
		16'hCA6A, 16'h5A51, 16'hF029, 16'h8010
	};

endpackage

/* rtl/pixelFifo.sv */
// Synchronous input pixel FIFO with combinational full flag, registered read data and error pulses
`timescale 1ns/1ns
`include "videoPost_settings.svh"

module pixelFifo
(
	input  logic        iVCLK,
	input  logic        iVRST,
	input  logic [15:0] i_wrData,
	input  logic        i_wrEn,
	input  logic        i_rdEn,
	output logic [15:0] o_rdData,
	output logic        o_full,
	output logic        o_empty,
	output logic        o_overflow,
	output logic        o_underflow
);

	localparam int addrW = $clog2(`FIFODEPTH);
	localparam logic [addrW:0] depthWords = `FIFODEPTH;

	// Circular buffer storage
	logic [15:0] mem [0:`FIFODEPTH-1];
	logic [addrW-1:0] wrPtr;
	logic [addrW-1:0] rdPtr;
	// Occupancy, one bit wider than the pointers
	logic [addrW:0] count;
	logic wrOk;
	logic rdOk;

	// ------------------------------
	// Flags
	// ------------------------------
	assign o_full = (count == depthWords);
	assign o_empty = (count == '0);
	// Write dropped when full, read refused when empty
	assign wrOk = i_wrEn && !o_full;
	assign rdOk = i_rdEn && !o_empty;

	// Pointers and occupancy
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrOk)
				wrPtr <= wrPtr + 1'b1;
			if (rdOk)
				rdPtr <= rdPtr + 1'b1;
			case ({wrOk, rdOk})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// ------------------------------
	// Storage and read port
	// ------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (wrOk)
			mem[wrPtr] <= i_wrData;
		// Data valid one cycle after the request
		if (rdOk)
			o_rdData <= mem[rdPtr];
		else if (i_rdEn)
			o_rdData <= '0;
	end

	// Single cycle error pulses toward the status register
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_overflow <= 1'b0;
			o_underflow <= 1'b0;
		end
		else
		begin
			o_overflow <= i_wrEn && o_full;
			o_underflow <= i_rdEn && o_empty;
		end
	end

endmodule

/* rtl/timingStartGate.sv */
// Start gate holding the raster generator until one line of pixels sits in the FIFO
`timescale 1ns/1ns
`include "videoPost_settings.svh"

module timingStartGate
(
	input  logic iVCLK,
	input  logic iVRST,
	input  logic i_wrAccepted,
	output logic o_timingRun
);

	localparam int cntW = $clog2(`PREFILL + 1);

	// Accepted writes since reset
	logic [cntW-1:0] wrCount;
	logic lastFill;

	// ------------------------------
	// Prefill counter
	// ------------------------------
	// The PREFILL-th accepted write releases timing
	assign lastFill = i_wrAccepted && (wrCount == cntW'(`PREFILL - 1));

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			wrCount <= '0;
			o_timingRun <= 1'b0;
		end
		else if (!o_timingRun)
		begin
			// Count only while the gate is still closed
			if (i_wrAccepted)
				wrCount <= wrCount + 1'b1;
			if (lastFill)
				o_timingRun <= 1'b1;
		end
		// Latched open until the next reset
	end

endmodule

/* rtl/videoTimingGen.sv */
// Raster generator producing sync, data enable, early FIFO read request and pixel position
`timescale 1ns/1ns
`include "videoPost_settings.svh"

module videoTimingGen
(
	input  logic       iVCLK,
	input  logic       iVRST,
	input  logic       i_run,
	output logic       o_hsync,
	output logic       o_vsync,
	output logic       o_de,
	output logic       o_rdReq,
	output logic [4:0] o_hPos,
	output logic       o_frameStart
);

	// Phase length for one axis
	function automatic int phaseLen(input videoTimingPkg::linePhase_t ph,
		input int lenSync, input int lenBack, input int lenActive, input int lenFront);
		case (ph)
			videoTimingPkg::PH_SYNC: return lenSync;
			videoTimingPkg::PH_BACK: return lenBack;
			videoTimingPkg::PH_ACTIVE: return lenActive;
			default: return lenFront;
		endcase
	endfunction

	// Raster order wraps from front porch back to sync
	function automatic videoTimingPkg::linePhase_t nextPhase(
		input videoTimingPkg::linePhase_t ph);
		return videoTimingPkg::linePhase_t'(ph + 2'd1);
	endfunction

	videoTimingPkg::linePhase_t hPhase;
	videoTimingPkg::linePhase_t vPhase;
	// Position within the current phase
	logic [4:0] hCnt;
	logic [3:0] vCnt;
	logic hLast;
	logic vLast;
	logic lineEnd;
	logic activeNow;
	logic frameHead;

	// ------------------------------
	// Phase end detection
	// ------------------------------
	assign hLast = (int'(hCnt) ==
		phaseLen(hPhase, `HSYNC, `HBACK, `HACTIVE, `HFRONT) - 1);
	assign vLast = (int'(vCnt) ==
		phaseLen(vPhase, `VSYNC, `VBACK, `VACTIVE, `VFRONT) - 1);
	assign lineEnd = hLast && (hPhase == videoTimingPkg::PH_FRONT);
	// First pixel clock of a frame
	assign frameHead = (vPhase == videoTimingPkg::PH_SYNC) && (vCnt == '0) &&
		(hPhase == videoTimingPkg::PH_SYNC) && (hCnt == '0);

	// Counters parked at frame start until released
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !i_run)
		begin
			hPhase <= videoTimingPkg::PH_SYNC;
			hCnt <= '0;
			vPhase <= videoTimingPkg::PH_SYNC;
			vCnt <= '0;
		end
		else
		begin
			if (hLast)
			begin
				hPhase <= nextPhase(hPhase);
				hCnt <= '0;
			end
			else
				hCnt <= hCnt + 1'b1;
			// Vertical steps once per line
			if (lineEnd)
			begin
				if (vLast)
				begin
					vPhase <= nextPhase(vPhase);
					vCnt <= '0;
				end
				else
					vCnt <= vCnt + 1'b1;
			end
		end
	end

	// ------------------------------
	// Outputs
	// ------------------------------
	// Request and position lead the registered enable by one cycle
	assign activeNow = i_run && (hPhase == videoTimingPkg::PH_ACTIVE) &&
		(vPhase == videoTimingPkg::PH_ACTIVE);
	assign o_rdReq = activeNow;
	assign o_hPos = hCnt;

	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_hsync <= 1'b0;
			o_vsync <= 1'b0;
			o_de <= 1'b0;
			o_frameStart <= 1'b0;
		end
		else
		begin
			o_hsync <= i_run && (hPhase == videoTimingPkg::PH_SYNC);
			o_vsync <= i_run && (vPhase == videoTimingPkg::PH_SYNC);
			o_de <= activeNow;
			// Pulse lines up with the VSync rising edge
			o_frameStart <= i_run && frameHead;
		end
	end

endmodule

/* rtl/hdmiPixelFormat.sv */
// Output formatter doing byte swap, colour-bar substitution, blanking and final sync alignment
`timescale 1ns/1ns
`include "videoPost_settings.svh"

module hdmiPixelFormat
(
	input  logic                   iVCLK,
	input  logic                   iVRST,
	input  logic                   i_hsync,
	input  logic                   i_vsync,
	input  logic                   i_de,
	input  logic [4:0]             i_hPos,
	input  logic [15:0]            i_fifoData,
	input  logic                   i_enable,
	input  videoCtrlPkg::videoSrc_t i_source,
	output logic                   o_hs,
	output logic                   o_vs,
	output logic                   o_de,
	output logic [15:0]            o_data
);

	// Position delayed to the FIFO data cycle
	logic [4:0] hPosD;
	logic [2:0] barIdx;
	logic [15:0] pixelOut;
	logic showPixel;

	always_ff @(posedge iVCLK)
	begin
		hPosD <= i_hPos;
	end

	// ------------------------------
	// Source select
	// ------------------------------
	// Eight equal bars across the active line
	assign barIdx = 3'((int'(hPosD) * 8) / `HACTIVE);
	assign showPixel = i_de && i_enable;

	always_comb
	begin
		if (i_source == videoCtrlPkg::SRC_BARS)
			pixelOut = videoCtrlPkg::barColour[barIdx];
		else
			// Transmitter wants luma in the low byte
			pixelOut = {i_fifoData[7:0], i_fifoData[15:8]};
	end

	// Final register stage, syncs keep running when disabled
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_hs <= 1'b0;
			o_vs <= 1'b0;
			o_de <= 1'b0;
			o_data <= '0;
		end
		else
		begin
			o_hs <= i_hsync;
			o_vs <= i_vsync;
			o_de <= showPixel;
			o_data <= showPixel ? pixelOut : 16'h0000;
		end
	end

endmodule

/* rtl/wbCtrlRegs.sv */
// Wishbone classic slave for output control, sticky FIFO error flags and frame count
`timescale 1ns/1ns

module wbCtrlRegs
(
	input  logic                    iVCLK,
	input  logic                    iVRST,
	input  logic                    i_wbCyc,
	input  logic                    i_wbStb,
	input  logic                    i_wbWe,
	input  logic [3:0]              i_wbAdr,
	input  logic [31:0]             i_wbDat,
	output logic [31:0]             o_wbDat,
	output logic                    o_wbAck,
	input  logic                    i_overflow,
	input  logic                    i_underflow,
	input  logic                    i_frameStart,
	output logic                    o_outEnable,
	output videoCtrlPkg::videoSrc_t o_source
);

	logic accessNow;
	logic writeNow;
	videoCtrlPkg::regAddr_t regSel;
	logic ovFlag;
	logic unFlag;
	logic [15:0] frameCount;
	logic [31:0] readVal;

	// One access per ack, stb held high gets no second ack
	assign accessNow = i_wbCyc && i_wbStb && !o_wbAck;
	assign writeNow = accessNow && i_wbWe;
	// Word registers, byte lanes ignored
	assign regSel = videoCtrlPkg::regAddr_t'(i_wbAdr[3:2]);

	// ------------------------------
	// Registers
	// ------------------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			o_wbAck <= 1'b0;
			o_outEnable <= 1'b1;
			o_source <= videoCtrlPkg::SRC_LIVE;
			ovFlag <= 1'b0;
			unFlag <= 1'b0;
			frameCount <= '0;
		end
		else
		begin
			o_wbAck <= accessNow;
			if (writeNow && (regSel == videoCtrlPkg::REG_CTRL))
			begin
				o_outEnable <= i_wbDat[0];
				o_source <= videoCtrlPkg::videoSrc_t'(i_wbDat[1]);
			end
			// Write one clears, a new event in the same cycle wins
			ovFlag <= (ovFlag && !(writeNow && (regSel == videoCtrlPkg::REG_STATUS) &&
				i_wbDat[0])) || i_overflow;
			unFlag <= (unFlag && !(writeNow && (regSel == videoCtrlPkg::REG_STATUS) &&
				i_wbDat[1])) || i_underflow;
			if (i_frameStart)
				frameCount <= frameCount + 1'b1;
		end
	end

	// Read mux, holes read zero
	always_comb
	begin
		case (regSel)
			videoCtrlPkg::REG_CTRL: readVal = {30'd0, o_source, o_outEnable};
			videoCtrlPkg::REG_STATUS: readVal = {30'd0, unFlag, ovFlag};
			videoCtrlPkg::REG_FRAMES: readVal = {16'd0, frameCount};
			default: readVal = 32'd0;
		endcase
	end

	always_ff @(posedge iVCLK)
	begin
		if (accessNow && !i_wbWe)
			o_wbDat <= readVal;
	end

endmodule

/* rtl/videoPostProcess.sv */
// Top level of the video back end, FIFO to start gate, raster generator and formatter plus registers
`timescale 1ns/1ns

module videoPostProcess
(
	input  logic        iVCLK,
	input  logic        iVRST,
	// Pixel input
	input  logic [15:0] i_pixel,
	input  logic        i_pixelValid,
	output logic        o_full,
	// Video output
	output logic        o_hs,
	output logic        o_vs,
	output logic        o_de,
	output logic [15:0] o_data,
	// Wishbone
	input  logic        i_wbCyc,
	input  logic        i_wbStb,
	input  logic        i_wbWe,
	input  logic [3:0]  i_wbAdr,
	input  logic [31:0] i_wbDat,
	output logic [31:0] o_wbDat,
	output logic        o_wbAck
);

	logic [15:0] fifoData;
	logic wrAccepted;
	logic overflow;
	logic underflow;
	logic timingRun;
	logic rdReq;
	logic hsync;
	logic vsync;
	logic de;
	logic [4:0] hPos;
	logic frameStart;
	logic outEnable;
	videoCtrlPkg::videoSrc_t source;

	// Writes the FIFO actually took
	assign wrAccepted = i_pixelValid && !o_full;

	// ------------------------------
	// Pipeline
	// ------------------------------
	pixelFifo pixelFifo_i (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.i_wrData(i_pixel), .i_wrEn(i_pixelValid),
		.i_rdEn(rdReq), .o_rdData(fifoData),
		// Empty only matters inside, for the underflow pulse
		.o_full(o_full), .o_empty(),
		.o_overflow(overflow), .o_underflow(underflow)
	);

	timingStartGate timingStartGate_i (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.i_wrAccepted(wrAccepted), .o_timingRun(timingRun)
	);

	videoTimingGen videoTimingGen_i (
		.iVCLK(iVCLK), .iVRST(iVRST), .i_run(timingRun),
		.o_hsync(hsync), .o_vsync(vsync), .o_de(de),
		.o_rdReq(rdReq), .o_hPos(hPos), .o_frameStart(frameStart)
	);

	hdmiPixelFormat hdmiPixelFormat_i (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.i_hsync(hsync), .i_vsync(vsync), .i_de(de),
		.i_hPos(hPos), .i_fifoData(fifoData),
		.i_enable(outEnable), .i_source(source),
		.o_hs(o_hs), .o_vs(o_vs), .o_de(o_de), .o_data(o_data)
	);

	// Control and status beside the pipeline
	wbCtrlRegs wbCtrlRegs_i (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
		.i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat),
		.o_wbDat(o_wbDat), .o_wbAck(o_wbAck),
		.i_overflow(overflow), .i_underflow(underflow),
		.i_frameStart(frameStart),
		.o_outEnable(outEnable), .o_source(source)
	);

endmodule

/* verif/videoPostProcessTb.sv */
// Self-checking testbench for the video back end, compiled from the file list as the simulation top
`timescale 1ns/1ns
`include "videoPost_settings.svh"

module videoPostProcessTb;

	localparam int lineLen = `HSYNC + `HBACK + `HACTIVE + `HFRONT;
	localparam int frameLines = `VSYNC + `VBACK + `VACTIVE + `VFRONT;
	localparam int hStart = `HSYNC + `HBACK;
	localparam int vStart = `VSYNC + `VBACK;
	// Frames the whole sequence needs, roughly
	localparam int testFrames = 14;
	localparam longint watchdogNs = longint'(testFrames) * frameLines * lineLen * 100 * 2;

	logic iVCLK;
	logic iVRST;
	logic [15:0] i_pixel;
	logic i_pixelValid;
	logic o_full;
	logic o_hs;
	logic o_vs;
	logic o_de;
	logic [15:0] o_data;
	logic i_wbCyc;
	logic i_wbStb;
	logic i_wbWe;
	logic [3:0] i_wbAdr;
	logic [31:0] i_wbDat;
	logic [31:0] o_wbDat;
	logic o_wbAck;

	int errors = 0;
	// 0 stopped, 1 flow controlled, 2 forced past full
	int feedMode = 0;
	// Reference model state
	logic [15:0] fifoModel [$];
	logic [15:0] pendingOut [$];
	int accepted;
	bit startPending;
	int rt;
	int vsCount;
	logic vsPrev;
	logic regEnable;
	logic regSource;
	logic effEnable;
	logic effSource;

	videoPostProcess videoPostProcess_i (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.i_pixel(i_pixel), .i_pixelValid(i_pixelValid), .o_full(o_full),
		.o_hs(o_hs), .o_vs(o_vs), .o_de(o_de), .o_data(o_data),
		.i_wbCyc(i_wbCyc), .i_wbStb(i_wbStb), .i_wbWe(i_wbWe),
		.i_wbAdr(i_wbAdr), .i_wbDat(i_wbDat),
		.o_wbDat(o_wbDat), .o_wbAck(o_wbAck)
	);

	initial
	begin
		iVCLK = 1'b0;
		forever #50 iVCLK = ~iVCLK;
	end

	// ------------------------------
	// Helpers
	// ------------------------------
	task automatic compareField(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		assert (actVal === expVal)
		else
		begin
			errors++;
			$display("MISMATCH at %0t ns: %s expected %h, got %h", $time, name, expVal, actVal);
		end
	endtask

	// Visible pixel test for raster cycle t counted from the first sync
	function automatic bit rasterActive(input int t);
		int h;
		int ln;
		h = t % lineLen;
		ln = (t / lineLen) % frameLines;
		return (h >= hStart) && (h < hStart + `HACTIVE) &&
			(ln >= vStart) && (ln < vStart + `VACTIVE);
	endfunction

	// One classic cycle, ack expected on the second edge after the strobe
	task automatic busAccess(input logic we, input videoCtrlPkg::regAddr_t sel,
		input logic [31:0] wdat, output logic [31:0] rdat);
		int waitCycles;
		@(posedge iVCLK);
		i_wbCyc <= 1'b1;
		i_wbStb <= 1'b1;
		i_wbWe <= we;
		i_wbAdr <= {sel, 2'b00};
		i_wbDat <= wdat;
		waitCycles = 0;
		do
		begin
			@(posedge iVCLK);
			waitCycles++;
		end
		while (!o_wbAck && waitCycles < 8);
		assert (o_wbAck && waitCycles == 2)
		else
		begin
			errors++;
			$display("Wishbone ack missing or late at %0t ns after %0d cycles", $time, waitCycles);
		end
		rdat = o_wbDat;
		i_wbCyc <= 1'b0;
		i_wbStb <= 1'b0;
		i_wbWe <= 1'b0;
	endtask

	task automatic writeReg(input videoCtrlPkg::regAddr_t sel, input logic [31:0] wdat);
		logic [31:0] unused;
		busAccess(1'b1, sel, wdat, unused);
	endtask

	task automatic readReg(input videoCtrlPkg::regAddr_t sel, input logic [31:0] expVal,
		input string name);
		logic [31:0] got;
		busAccess(1'b0, sel, 32'd0, got);
		compareField(name, expVal, got);
	endtask

	// Returns on the falling edge after n more VSync starts
	task automatic waitFrames(input int n);
		int target;
		@(negedge iVCLK);
		target = vsCount + n;
		while (vsCount < target)
			@(negedge iVCLK);
	endtask

	// ------------------------------
	// Pixel source
	// ------------------------------
	initial
	begin
		bit room;
		bit gap;
		logic drive;
		void'($urandom(32'h0b0fbdd5));
		forever
		begin
			// Model occupancy is stable here, two words of headroom
			@(negedge iVCLK);
			room = fifoModel.size() < `FIFODEPTH - 2;
			gap = ($urandom % 4) == 0;
			@(posedge iVCLK);
			case (feedMode)
				1: drive = room && !gap;
				2: drive = 1'b1;
				default: drive = 1'b0;
			endcase
			i_pixelValid <= drive;
			if (drive)
				i_pixel <= 16'($urandom);
		end
	end

	// ------------------------------
	// Reference model and output checks
	// ------------------------------
	always @(posedge iVCLK)
	begin
		int sizeNow;
		int ot;
		logic [15:0] popped;
		logic expHs;
		logic expVs;
		logic expDe;
		logic [15:0] expData;
		if (iVRST)
		begin
			fifoModel.delete();
			pendingOut.delete();
			accepted = 0;
			startPending = 1'b0;
			rt = -1;
			vsCount = 0;
			vsPrev = 1'b0;
			regEnable = 1'b1;
			regSource = 1'b0;
			effEnable = 1'b1;
			effSource = 1'b0;
		end
		else
		begin
			sizeNow = fifoModel.size();
			compareField("o_full", 32'(sizeNow == `FIFODEPTH), 32'(o_full));
			// Raster starts the cycle after the prefill write
			if (rt >= 0)
				rt++;
			else if (startPending)
				rt = 0;
			// Outputs trail the raster by the read lead
			ot = rt - `READLEAD;
			expHs = 1'b0;
			expVs = 1'b0;
			expDe = 1'b0;
			expData = 16'h0000;
			if (ot >= 0)
			begin
				expHs = (ot % lineLen) < `HSYNC;
				expVs = ((ot / lineLen) % frameLines) < `VSYNC;
				if (rasterActive(ot))
				begin
					popped = pendingOut.pop_front();
					expDe = effEnable;
					if (!effEnable)
						expData = 16'h0000;
					else if (effSource)
						expData = videoCtrlPkg::barColour[((ot % lineLen) - hStart) * 8 / `HACTIVE];
					else
						expData = {popped[7:0], popped[15:8]};
				end
			end
			compareField("o_hs", 32'(expHs), 32'(o_hs));
			compareField("o_vs", 32'(expVs), 32'(o_vs));
			compareField("o_de", 32'(expDe), 32'(o_de));
			compareField("o_data", 32'(expData), 32'(o_data));
			// Early read, an empty FIFO gives zero
			if (rt >= 0 && rasterActive(rt))
			begin
				if (sizeNow > 0)
					pendingOut.push_back(fifoModel.pop_front());
				else
					pendingOut.push_back(16'h0000);
			end
			// Writes land only when there was room before the edge
			if (i_pixelValid && sizeNow < `FIFODEPTH)
			begin
				fifoModel.push_back(i_pixel);
				accepted++;
				if (accepted == `PREFILL)
					startPending = 1'b1;
			end
			if (o_vs && !vsPrev)
				vsCount++;
			vsPrev = o_vs;
			// CTRL written at the ack edge applies from the next sample
			if (o_wbAck && i_wbWe && i_wbAdr[3:2] == 2'(videoCtrlPkg::REG_CTRL))
			begin
				regEnable = i_wbDat[0];
				regSource = i_wbDat[1];
			end
			effEnable = regEnable;
			effSource = regSource;
		end
	end

	// Ack is a single cycle pulse
	ackPulse: assert property (@(posedge iVCLK) disable iff (iVRST) o_wbAck |=> !o_wbAck)
	else
	begin
		errors++;
		$display("Wishbone ack held for more than one cycle at %0t ns", $time);
	end

	// Ack only answers a strobe
	ackReply: assert property (@(posedge iVCLK) disable iff (iVRST)
		o_wbAck |-> $past(i_wbCyc && i_wbStb))
	else
	begin
		errors++;
		$display("Wishbone ack without a strobe at %0t ns", $time);
	end

	prefillHold: assert property (@(posedge iVCLK) disable iff (iVRST)
		o_de |-> accepted >= `PREFILL)
	else
	begin
		errors++;
		$display("Data enable before one line was buffered at %0t ns", $time);
	end

	// ------------------------------
	// Sequence
	// ------------------------------
	initial
	begin
		int framesSeen;
		logic [31:0] frames0;
		iVRST = 1'b1;
		i_pixel = 16'h0000;
		i_pixelValid = 1'b0;
		i_wbCyc = 1'b0;
		i_wbStb = 1'b0;
		i_wbWe = 1'b0;
		i_wbAdr = 4'h0;
		i_wbDat = 32'd0;
		repeat (16) @(posedge iVCLK);
		iVRST <= 1'b0;
		@(negedge iVCLK);
		compareField("o_wbAck", 32'd0, 32'(o_wbAck));
		feedMode = 1;
		// Prefill, then live video
		waitFrames(2);
		readReg(videoCtrlPkg::REG_CTRL, 32'h1, "CTRL read");
		// Colour bars for a frame
		writeReg(videoCtrlPkg::REG_CTRL, 32'h3);
		readReg(videoCtrlPkg::REG_CTRL, 32'h3, "CTRL read");
		waitFrames(1);
		// Output disabled, syncs keep running
		writeReg(videoCtrlPkg::REG_CTRL, 32'h0);
		readReg(videoCtrlPkg::REG_CTRL, 32'h0, "CTRL read");
		waitFrames(1);
		writeReg(videoCtrlPkg::REG_CTRL, 32'h1);
		readReg(videoCtrlPkg::REG_CTRL, 32'h1, "CTRL read");
		// Frame counter against observed VSync starts
		waitFrames(1);
		framesSeen = vsCount;
		busAccess(1'b0, videoCtrlPkg::REG_FRAMES, 32'd0, frames0);
		compareField("FRAMES read", 32'(framesSeen), frames0);
		waitFrames(2);
		readReg(videoCtrlPkg::REG_FRAMES, 32'(framesSeen) + 32'd2, "FRAMES read");
		readReg(videoCtrlPkg::REG_STATUS, 32'h0, "STATUS read");
		// Overflow by pushing past full
		@(negedge iVCLK);
		feedMode = 2;
		while (fifoModel.size() < `FIFODEPTH)
			@(negedge iVCLK);
		repeat (4) @(negedge iVCLK);
		feedMode = 1;
		repeat (4) @(negedge iVCLK);
		readReg(videoCtrlPkg::REG_STATUS, 32'h1, "STATUS read");
		writeReg(videoCtrlPkg::REG_STATUS, 32'h1);
		readReg(videoCtrlPkg::REG_STATUS, 32'h0, "STATUS read");
		// Underflow by starving the FIFO
		@(negedge iVCLK);
		feedMode = 0;
		waitFrames(3);
		readReg(videoCtrlPkg::REG_STATUS, 32'h2, "STATUS read");
		@(negedge iVCLK);
		feedMode = 1;
		waitFrames(1);
		writeReg(videoCtrlPkg::REG_STATUS, 32'h2);
		readReg(videoCtrlPkg::REG_STATUS, 32'h0, "STATUS read");
		waitFrames(1);
		$display("Run complete: %0d errors, %0d pixels accepted, %0d frames", errors,
			accepted, vsCount);
		if (errors == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

	// Watchdog, twice the expected run length
	initial
	begin
		#(watchdogNs);
		$display("Timeout: the run did not finish within %0d ns", watchdogNs);
		$display("Run stopped: %0d errors", errors);
		$display("** FAIL **");
		$finish;
	end

endmodule

/* videoPostProcess.f */
+incdir+include
rtl/videoTimingPkg.sv
rtl/videoCtrlPkg.sv
rtl/pixelFifo.sv
rtl/timingStartGate.sv
rtl/videoTimingGen.sv
rtl/hdmiPixelFormat.sv
rtl/wbCtrlRegs.sv
rtl/videoPostProcess.sv
verif/videoPostProcessTb.sv

/* Makefile */
SIM      := verilator
TOP      := videoPostProcessTb
FILELIST := videoPostProcess.f
FLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP)
BUILDDIR := obj_dir
LOG      := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log for a pass"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
